// File: list.f
source/sq_pkg.sv
source/csa_tree.sv
source/square_array.sv
source/fold_reduce.sv
source/final_subtract.sv
source/modsq_config.sv
source/modsq_control.sv
source/modsq_top.sv
verification/modsq_props.sv
verification/modsq_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module modsq_tb -f list.f
./obj_dir/Vmodsq_tb +verilator+error+limit+1000 | tee sim.log
if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1

// File: source/csa_tree.sv
// Carry-save compressor tree, reduces many equal-width terms to one carry and one sum
module csa_tree #(
    parameter int NUM_TERMS  = 3,
    parameter int TERM_WIDTH = 16
) (
    input  logic [TERM_WIDTH-1:0] terms [NUM_TERMS],
    output logic [TERM_WIDTH-1:0] carry,
    output logic [TERM_WIDTH-1:0] sum
);

    generate
        if (NUM_TERMS == 1) begin : g_single
            assign carry = '0;
            assign sum   = terms[0];
        end else if (NUM_TERMS == 2) begin : g_pair
            assign carry = terms[1];
            assign sum   = terms[0];
        end else begin : g_level
            localparam int NUM_GROUPS = NUM_TERMS / 3;
            localparam int NUM_LEFT   = NUM_TERMS % 3;
            localparam int NUM_NEXT   = 2 * NUM_GROUPS + NUM_LEFT;

            logic [TERM_WIDTH-1:0] next_terms [NUM_NEXT];

            // One 3:2 compressor per group of three terms
            for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_csa
                logic [TERM_WIDTH-1:0] a;
                logic [TERM_WIDTH-1:0] b;
                logic [TERM_WIDTH-1:0] c;
                logic [TERM_WIDTH-1:0] maj;

                assign a   = terms[3*g];
                assign b   = terms[3*g+1];
                assign c   = terms[3*g+2];
                assign maj = (a & b) | (a & c) | (b & c);

                // Carries weigh one bit position more
                assign next_terms[2*g]   = {maj[TERM_WIDTH-2:0], 1'b0};
                assign next_terms[2*g+1] = a ^ b ^ c;
            end

            // Leftover terms go down untouched
            for (genvar n = 0; n < NUM_LEFT; n++) begin : g_left
                assign next_terms[2*NUM_GROUPS+n] = terms[3*NUM_GROUPS+n];
            end

            csa_tree #(
                .NUM_TERMS  (NUM_NEXT),
                .TERM_WIDTH (TERM_WIDTH)
            ) csa_tree_inst (
                .terms (next_terms),
                .carry (carry),
                .sum   (sum)
            );
        end
    endgenerate

endmodule

// File: source/final_subtract.sv
// Final stage, resolves pending carries to binary and subtracts P until the value is below P
module final_subtract #(
    parameter int LIMBS = sq_pkg::DEFAULT_LIMBS
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          resolve_load,
    input  logic          sub_enable,
    input  sq_pkg::limb_t limbs [LIMBS+1],
    input  sq_pkg::word_t modulus [LIMBS],
    output logic          below_p,
    output sq_pkg::word_t result [LIMBS]
);

    localparam int WORD_LEN = sq_pkg::DEFAULT_WORD_LEN;
    localparam int ACC_W    = WORD_LEN + 2;
    localparam int DIFF_W   = WORD_LEN + 1;

    sq_pkg::word_t value [LIMBS+1];
    sq_pkg::word_t resolved [LIMBS+1];
    sq_pkg::word_t diff [LIMBS+1];
    sq_pkg::word_t p_ext [LIMBS+1];

    // Carry ripple from the lowest limb up
    always_comb begin
        logic [ACC_W-1:0]          acc;
        logic [ACC_W-WORD_LEN-1:0] carry;
        carry = '0;
        for (int j = 0; j <= LIMBS; j++) begin
            acc         = ACC_W'(limbs[j]) + ACC_W'(carry);
            resolved[j] = acc[WORD_LEN-1:0];
            carry       = acc[ACC_W-1:WORD_LEN];
        end
    end

    // P padded to the width of the held value
    always_comb begin
        for (int j = 0; j < LIMBS; j++) begin
            p_ext[j] = modulus[j];
        end
        p_ext[LIMBS] = '0;
    end

    // Trial subtraction, a borrow out of the top word means value < P
    always_comb begin
        logic [DIFF_W-1:0] d;
        logic              borrow;
        borrow = 1'b0;
        for (int j = 0; j <= LIMBS; j++) begin
            d       = {1'b0, value[j]} - {1'b0, p_ext[j]} - DIFF_W'(borrow);
            diff[j] = d[WORD_LEN-1:0];
            borrow  = d[WORD_LEN];
        end
        below_p = borrow;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int j = 0; j <= LIMBS; j++) begin
                value[j] <= '0;
            end
        end else if (resolve_load) begin
            value <= resolved;
        end else if (sub_enable && !below_p) begin
            value <= diff;
        end
    end

    always_comb begin
        for (int j = 0; j < LIMBS; j++) begin
            result[j] = value[j];
        end
    end

endmodule

// File: source/fold_reduce.sv
// Fold stage, multiplies the high words by their residues and adds them to the low words
module fold_reduce #(
    parameter int LIMBS = sq_pkg::DEFAULT_LIMBS
) (
    input  sq_pkg::word_t col_words [2*LIMBS+4],
    input  sq_pkg::word_t residues [(LIMBS+2)*LIMBS],
    output sq_pkg::limb_t next_limbs [LIMBS+1]
);

    localparam int WORD_LEN   = sq_pkg::DEFAULT_WORD_LEN;
    localparam int LIMB_W     = WORD_LEN + 1;
    localparam int NUM_RES    = LIMBS + 2;
    localparam int PROD_W     = 2 * WORD_LEN;
    // Low word, one low half and one high half per residue
    localparam int FOLD_TERMS = 2 * NUM_RES + 1;
    localparam int FOLD_W     = WORD_LEN + $clog2(FOLD_TERMS);

    logic [PROD_W-1:0] prod [NUM_RES][LIMBS];
    logic [FOLD_W-1:0] fold_sum [LIMBS+1];

    // High word LIMBS+k times each word of residue k
    always_comb begin
        for (int k = 0; k < NUM_RES; k++) begin
            for (int j = 0; j < LIMBS; j++) begin
                prod[k][j] = PROD_W'(col_words[LIMBS + k]) * PROD_W'(residues[k * LIMBS + j]);
            end
        end
    end

    for (genvar j = 0; j <= LIMBS; j++) begin : g_col
        logic [FOLD_W-1:0] terms [FOLD_TERMS];
        logic [FOLD_W-1:0] col_carry;
        logic [FOLD_W-1:0] col_partial;

        if (j < LIMBS) begin : g_low
            assign terms[0] = FOLD_W'(col_words[j]);
        end else begin : g_top
            assign terms[0] = '0;
        end

        for (genvar k = 0; k < NUM_RES; k++) begin : g_res
            if (j < LIMBS) begin : g_lo_half
                assign terms[1+k] = FOLD_W'(prod[k][j][WORD_LEN-1:0]);
            end else begin : g_no_lo
                assign terms[1+k] = '0;
            end
            if (j > 0) begin : g_hi_half
                assign terms[1+NUM_RES+k] = FOLD_W'(prod[k][j-1][PROD_W-1:WORD_LEN]);
            end else begin : g_no_hi
                assign terms[1+NUM_RES+k] = '0;
            end
        end

        csa_tree #(
            .NUM_TERMS  (FOLD_TERMS),
            .TERM_WIDTH (FOLD_W)
        ) csa_tree_inst (
            .terms (terms),
            .carry (col_carry),
            .sum   (col_partial)
        );

        assign fold_sum[j] = col_carry + col_partial;
    end

    // Single carry split, each limb keeps at most one pending carry bit
    always_comb begin
        next_limbs[0] = LIMB_W'(fold_sum[0][WORD_LEN-1:0]);
        for (int j = 1; j <= LIMBS; j++) begin
            next_limbs[j] = LIMB_W'(fold_sum[j][WORD_LEN-1:0])
                          + LIMB_W'(fold_sum[j-1][FOLD_W-1:WORD_LEN]);
        end
    end

endmodule

// File: source/modsq_config.sv
// Configuration registers, holds the modulus, the residue table and the iteration count
module modsq_config #(
    parameter int LIMBS = sq_pkg::DEFAULT_LIMBS
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              busy,
    input  logic              cfg_write,
    input  sq_pkg::cfg_addr_t cfg_addr,
    input  sq_pkg::word_t     cfg_data,
    output sq_pkg::word_t     modulus [LIMBS],
    output sq_pkg::word_t     residues [(LIMBS+2)*LIMBS],
    output sq_pkg::count_t    iterations
);

    localparam int NUM_RES_WORDS = (LIMBS + 2) * LIMBS;
    localparam int RES_BASE      = LIMBS;
    localparam int T_LOW_ADDR    = RES_BASE + NUM_RES_WORDS;
    localparam int T_HIGH_ADDR   = T_LOW_ADDR + 1;

    logic write_ok;

    // Table stays frozen for the whole run
    assign write_ok = cfg_write && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LIMBS; i++) begin
                modulus[i] <= '0;
            end
            for (int i = 0; i < NUM_RES_WORDS; i++) begin
                residues[i] <= '0;
            end
            iterations <= '0;
        end else if (write_ok) begin
            for (int i = 0; i < LIMBS; i++) begin
                if (cfg_addr == sq_pkg::cfg_addr_t'(i)) begin
                    modulus[i] <= cfg_data;
                end
            end
            // Residue k word j sits at RES_BASE + k*LIMBS + j
            for (int i = 0; i < NUM_RES_WORDS; i++) begin
                if (cfg_addr == sq_pkg::cfg_addr_t'(RES_BASE + i)) begin
                    residues[i] <= cfg_data;
                end
            end
            if (cfg_addr == sq_pkg::cfg_addr_t'(T_LOW_ADDR)) begin
                iterations[15:0] <= cfg_data;
            end
            if (cfg_addr == sq_pkg::cfg_addr_t'(T_HIGH_ADDR)) begin
                iterations[31:16] <= cfg_data;
            end
        end
    end

endmodule

// File: source/modsq_control.sv
// Squaring controller, FSM, iteration counter and the working limb and column registers
module modsq_control #(
    parameter int LIMBS = sq_pkg::DEFAULT_LIMBS
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  sq_pkg::word_t  x_in [LIMBS],
    input  sq_pkg::count_t iterations,
    input  sq_pkg::limb_t  next_limbs [LIMBS+1],
    input  sq_pkg::word_t  col_words_in [2*LIMBS+4],
    input  logic           below_p,
    output sq_pkg::limb_t  limbs [LIMBS+1],
    output sq_pkg::word_t  col_words_reg [2*LIMBS+4],
    output logic           resolve_load,
    output logic           sub_enable,
    output logic           busy,
    output logic           done
);

    sq_pkg::modsq_state_t state;
    sq_pkg::modsq_state_t state_next;
    sq_pkg::count_t       remaining;
    logic                 accept;

    // Start only counts in idle
    assign accept = (state == sq_pkg::IDLE) && start;

    always_comb begin
        state_next = state;
        case (state)
            sq_pkg::IDLE: begin
                if (start) begin
                    // T of zero skips the squaring loop
                    state_next = (iterations == '0) ? sq_pkg::RESOLVE : sq_pkg::SQUARE;
                end
            end
            sq_pkg::SQUARE: state_next = sq_pkg::FOLD;
            sq_pkg::FOLD: begin
                if (remaining == sq_pkg::count_t'(1)) begin
                    state_next = sq_pkg::RESOLVE;
                end else begin
                    state_next = sq_pkg::SQUARE;
                end
            end
            sq_pkg::RESOLVE: state_next = sq_pkg::SUBTRACT;
            sq_pkg::SUBTRACT: begin
                if (below_p) begin
                    state_next = sq_pkg::DONE;
                end
            end
            default: state_next = sq_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= sq_pkg::IDLE;
            remaining <= '0;
        end else begin
            state <= state_next;
            if (accept) begin
                remaining <= iterations;
            end else if (state == sq_pkg::FOLD) begin
                remaining <= remaining - sq_pkg::count_t'(1);
            end
        end
    end

    // Working limbs and the column words between the two squaring stages
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < LIMBS; i++) begin
                limbs[i] <= {1'b0, x_in[i]};
            end
            limbs[LIMBS] <= '0;
        end else if (state == sq_pkg::FOLD) begin
            limbs <= next_limbs;
        end
        if (state == sq_pkg::SQUARE) begin
            col_words_reg <= col_words_in;
        end
    end

    assign resolve_load = (state == sq_pkg::RESOLVE);
    assign sub_enable   = (state == sq_pkg::SUBTRACT);
    assign done         = (state == sq_pkg::DONE);
    assign busy         = (state == sq_pkg::SQUARE) || (state == sq_pkg::FOLD)
                       || (state == sq_pkg::RESOLVE) || (state == sq_pkg::SUBTRACT);

endmodule

// File: source/modsq_top.sv
// Modular squaring engine top, computes x^(2^T) mod P from the configured modulus
module modsq_top #(
    parameter int LIMBS = sq_pkg::DEFAULT_LIMBS
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  sq_pkg::word_t     x_in [LIMBS],
    input  logic              cfg_write,
    input  sq_pkg::cfg_addr_t cfg_addr,
    input  sq_pkg::word_t     cfg_data,
    output logic              busy,
    output logic              done,
    output sq_pkg::word_t     result [LIMBS]
);

    sq_pkg::word_t  modulus [LIMBS];
    sq_pkg::word_t  residues [(LIMBS+2)*LIMBS];
    sq_pkg::count_t iterations;
    sq_pkg::limb_t  limbs [LIMBS+1];
    sq_pkg::limb_t  next_limbs [LIMBS+1];
    sq_pkg::word_t  col_words [2*LIMBS+4];
    sq_pkg::word_t  col_words_reg [2*LIMBS+4];
    logic           resolve_load;
    logic           sub_enable;
    logic           below_p;

    modsq_config #(.LIMBS(LIMBS)) modsq_config_inst (
        .clk        (clk),
        .reset      (reset),
        .busy       (busy),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .modulus    (modulus),
        .residues   (residues),
        .iterations (iterations)
    );

    modsq_control #(.LIMBS(LIMBS)) modsq_control_inst (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .x_in          (x_in),
        .iterations    (iterations),
        .next_limbs    (next_limbs),
        .col_words_in  (col_words),
        .below_p       (below_p),
        .limbs         (limbs),
        .col_words_reg (col_words_reg),
        .resolve_load  (resolve_load),
        .sub_enable    (sub_enable),
        .busy          (busy),
        .done          (done)
    );

    // Squaring cycle
    square_array #(.LIMBS(LIMBS)) square_array_inst (
        .limbs     (limbs),
        .col_words (col_words)
    );

    // Fold cycle, works on the registered column words
    fold_reduce #(.LIMBS(LIMBS)) fold_reduce_inst (
        .col_words  (col_words_reg),
        .residues   (residues),
        .next_limbs (next_limbs)
    );

    final_subtract #(.LIMBS(LIMBS)) final_subtract_inst (
        .clk          (clk),
        .reset        (reset),
        .resolve_load (resolve_load),
        .sub_enable   (sub_enable),
        .limbs        (limbs),
        .modulus      (modulus),
        .below_p      (below_p),
        .result       (result)
    );

endmodule

// File: source/sq_pkg.sv
// Modular squaring package, shared word types, default sizes and controller states
package sq_pkg;

    // Limb word width, fixed because word_t is built on it
    localparam int DEFAULT_WORD_LEN = 16;

    // Number of modulus words
    localparam int DEFAULT_LIMBS = 4;

    // One binary word of the modulus, a residue or the result
    typedef logic [DEFAULT_WORD_LEN-1:0] word_t;

    // Redundant limb, one word plus a single pending carry bit
    typedef logic [DEFAULT_WORD_LEN:0] limb_t;

    // Iteration count T
    typedef logic [31:0] count_t;

    typedef logic [7:0] cfg_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        SQUARE,
        FOLD,
        RESOLVE,
        SUBTRACT,
        DONE
    } modsq_state_t;

endpackage

// File: source/square_array.sv
// Squaring array, column products of the limb vector compressed and split into binary words
module square_array #(
    parameter int LIMBS = sq_pkg::DEFAULT_LIMBS
) (
    input  sq_pkg::limb_t limbs [LIMBS+1],
    output sq_pkg::word_t col_words [2*LIMBS+4]
);

    localparam int WORD_LEN  = sq_pkg::DEFAULT_WORD_LEN;
    localparam int LIMB_W    = WORD_LEN + 1;
    localparam int NUM_COLS  = 2 * LIMBS + 1;
    localparam int COL_TERMS = LIMBS + 1;
    // Wide enough for every product of the fullest column
    localparam int COL_W     = 2 * LIMB_W + $clog2(COL_TERMS);
    localparam int NUM_WORDS = 2 * LIMBS + 4;
    localparam int ALIGN_W   = WORD_LEN + 2;

    logic [COL_W-1:0]   col_sum [NUM_COLS];
    logic [ALIGN_W-1:0] aligned [NUM_WORDS];

    for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
        logic [COL_W-1:0] terms [COL_TERMS];
        logic [COL_W-1:0] col_carry;
        logic [COL_W-1:0] col_partial;

        for (genvar n = 0; n < COL_TERMS; n++) begin : g_term
            if (c - n >= 0 && c - n <= LIMBS) begin : g_prod
                // Ordered pairs, so off-diagonal products appear twice
                assign terms[n] = COL_W'(limbs[n]) * COL_W'(limbs[c-n]);
            end else begin : g_none
                assign terms[n] = '0;
            end
        end

        csa_tree #(
            .NUM_TERMS  (COL_TERMS),
            .TERM_WIDTH (COL_W)
        ) csa_tree_inst (
            .terms (terms),
            .carry (col_carry),
            .sum   (col_partial)
        );

        assign col_sum[c] = col_carry + col_partial;
    end

    // First split, slices of each column land in three neighbouring words
    always_comb begin
        for (int w = 0; w < NUM_WORDS; w++) begin
            aligned[w] = '0;
        end
        for (int c = 0; c < NUM_COLS; c++) begin
            aligned[c]     = aligned[c] + ALIGN_W'(col_sum[c][WORD_LEN-1:0]);
            aligned[c + 1] = aligned[c + 1] + ALIGN_W'(col_sum[c][2*WORD_LEN-1:WORD_LEN]);
            aligned[c + 2] = aligned[c + 2] + ALIGN_W'(col_sum[c][COL_W-1:2*WORD_LEN]);
        end
    end

    // Second split, short ripple of the small word overflows
    always_comb begin
        logic [ALIGN_W-1:0]          acc;
        logic [ALIGN_W-WORD_LEN-1:0] ripple;
        ripple = '0;
        for (int w = 0; w < NUM_WORDS; w++) begin
            acc          = aligned[w] + ALIGN_W'(ripple);
            col_words[w] = acc[WORD_LEN-1:0];
            ripple       = acc[ALIGN_W-1:WORD_LEN];
        end
    end

endmodule

// File: verification/modsq_props.sv
// Bound checks on the done pulse, the busy level and start acceptance of the squaring engine
module modsq_props (
    input logic clk,
    input logic reset,
    input logic start,
    input logic busy,
    input logic done
);

    int unsigned fail_count = 0;

    // Done is a single-cycle pulse
    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    busy_done_apart: assert property (@(posedge clk) disable iff (reset) !(busy && done))
        else begin
            fail_count++;
            $error("busy and done were high in the same cycle");
        end

    // Busy only starts from an idle cycle that saw start
    busy_from_start: assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> $past(start && !busy && !done))
        else begin
            fail_count++;
            $error("busy rose without a start in idle");
        end

endmodule

// File: verification/modsq_tb.sv
// Testbench for the modular squaring engine, checks x^(2^T) mod P against a reference model
module modsq_tb;

    localparam int LIMBS      = 4;
    localparam int WORD_LEN   = sq_pkg::DEFAULT_WORD_LEN;
    localparam int NUM_RES    = LIMBS + 2;
    localparam int T_LOW_ADDR = LIMBS + NUM_RES * LIMBS;
    // Covers the longest run of subtractions for a legal P
    localparam int DONE_MARGIN = 500000;
    localparam int BUSY_LIMIT  = 20;
    localparam logic [63:0] KNOWN_P = 64'h0001_2345_6789_abcd;

    logic              clk;
    logic              reset;
    logic              start;
    sq_pkg::word_t     x_in [LIMBS];
    logic              cfg_write;
    sq_pkg::cfg_addr_t cfg_addr;
    sq_pkg::word_t     cfg_data;
    logic              busy;
    logic              done;
    sq_pkg::word_t     result [LIMBS];

    logic [63:0]    result_value;
    logic [63:0]    expected_q [$];
    logic [63:0]    cur_p;
    sq_pkg::count_t cur_t;
    logic [63:0]    held_result;
    logic           held_valid;
    logic           expect_idle;
    int unsigned    error_count;
    int unsigned    done_count;

    modsq_top #(.LIMBS(LIMBS)) modsq_top_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .x_in      (x_in),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    bind modsq_top modsq_props modsq_props_inst (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .busy  (busy),
        .done  (done)
    );

    assign result_value = {result[3], result[2], result[1], result[0]};

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Expected x^(2^T) mod P by repeated squaring in 128 bits
    function automatic logic [63:0] ref_modsq(input logic [63:0] x, input logic [63:0] p,
                                              input sq_pkg::count_t t);
        logic [127:0] acc;
        acc = {64'b0, x} % {64'b0, p};
        for (int unsigned i = 0; i < t; i++) begin
            acc = (acc * acc) % {64'b0, p};
        end
        return acc[63:0];
    endfunction

    // 2^e mod P by doubling
    function automatic logic [63:0] pow2_mod(input int e, input logic [63:0] p);
        logic [64:0] r;
        r = 65'd1;
        for (int i = 0; i < e; i++) begin
            r = r << 1;
            if (r >= {1'b0, p}) begin
                r = r - {1'b0, p};
            end
        end
        return r[63:0];
    endfunction

    task automatic write_word(input int addr, input sq_pkg::word_t data);
        cfg_write <= 1'b1;
        cfg_addr  <= sq_pkg::cfg_addr_t'(addr);
        cfg_data  <= data;
        @(posedge clk);
    endtask

    task automatic load_config(input logic [63:0] p, input sq_pkg::count_t t);
        logic [63:0] res;
        for (int j = 0; j < LIMBS; j++) begin
            write_word(j, p[16*j +: 16]);
        end
        for (int k = 0; k < NUM_RES; k++) begin
            res = pow2_mod(WORD_LEN * (LIMBS + k), p);
            for (int j = 0; j < LIMBS; j++) begin
                write_word(LIMBS + k * LIMBS + j, res[16*j +: 16]);
            end
        end
        write_word(T_LOW_ADDR, t[15:0]);
        write_word(T_LOW_ADDR + 1, t[31:16]);
        cfg_write <= 1'b0;
        cur_p = p;
        cur_t = t;
    endtask

    task automatic start_run(input logic [63:0] x);
        expected_q.push_back(ref_modsq(x, cur_p, cur_t));
        start <= 1'b1;
        for (int i = 0; i < LIMBS; i++) begin
            x_in[i] <= x[16*i +: 16];
        end
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_for_done();
        int unsigned limit;
        int unsigned cycles;
        limit = 2 * cur_t + DONE_MARGIN;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!done && cycles < limit);
        if (!done) begin
            $display("Timeout, no done pulse within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic wait_for_busy();
        int unsigned cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!busy && cycles < BUSY_LIMIT);
        if (!busy) begin
            $display("Timeout, busy did not rise after start");
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic run_case(input logic [63:0] x, input logic [63:0] p, input sq_pkg::count_t t);
        load_config(p, t);
        start_run(x);
        wait_for_done();
    endtask

    // Compares every done against the oldest pending expectation
    always @(posedge clk) begin
        logic [63:0] expected;
        if (!reset) begin
            if (expect_idle) begin
                assert (busy == 1'b0) else begin
                    error_count++;
                    $display("** Error busy: expected 0x0, actual 0x%h", busy);
                end
                assert (done == 1'b0) else begin
                    error_count++;
                    $display("** Error done: expected 0x0, actual 0x%h", done);
                end
            end
            if (done) begin
                done_count++;
                assert (expected_q.size() != 0) else begin
                    error_count++;
                    $display("A done pulse arrived with no run pending");
                end
                if (expected_q.size() != 0) begin
                    expected = expected_q.pop_front();
                    assert (result_value == expected) else begin
                        error_count++;
                        $display("** Error result: expected 0x%016h, actual 0x%016h",
                                 expected, result_value);
                    end
                end
                held_result = result_value;
                held_valid  = 1'b1;
            end else if (held_valid && !busy) begin
                assert (result_value == held_result) else begin
                    error_count++;
                    $display("** Error result: expected 0x%016h, actual 0x%016h",
                             held_result, result_value);
                end
            end
        end
    end

    initial begin
        logic [63:0]    x;
        logic [63:0]    p;
        sq_pkg::count_t t;
        int unsigned    dones_before;
        int unsigned    prop_fails;
        void'($urandom(32'hd4ee));
        reset       = 1'b1;
        start       = 1'b0;
        cfg_write   = 1'b0;
        cfg_addr    = '0;
        cfg_data    = '0;
        for (int i = 0; i < LIMBS; i++) begin
            x_in[i] = '0;
        end
        cur_p       = KNOWN_P;
        cur_t       = '0;
        held_valid  = 1'b0;
        expect_idle = 1'b0;
        error_count = 0;
        done_count  = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Quiet outputs through reset release and configuration
        expect_idle = 1'b1;
        load_config(KNOWN_P, 1);
        repeat (4) @(posedge clk);
        expect_idle = 1'b0;

        // Known values, with x above P so subtractions occur
        start_run(64'h0000_0000_1234_5678);
        wait_for_done();
        run_case(64'h0003_0000_0000_0007, KNOWN_P, 1);
        run_case(64'h0003_0000_0000_0007, KNOWN_P, 0);
        run_case(64'h0000_0000_0000_beef, KNOWN_P, 0);

        for (int n = 0; n < 20; n++) begin
            p = {4'h0, 28'($urandom), $urandom};
            if (p[59:48] == '0) begin
                p[48] = 1'b1;
            end
            x = {$urandom, $urandom};
            t = sq_pkg::count_t'($urandom % 25);
            run_case(x, p, t);
        end

        // Start pulses and writes during busy must not disturb the run
        p = {4'h0, 28'($urandom), $urandom} | 64'h0001_0000_0000_0000;
        load_config(p, 20);
        dones_before = done_count;
        start_run({$urandom, $urandom});
        wait_for_busy();
        start <= 1'b1;
        x_in[0] <= 16'h5a5a;
        @(posedge clk);
        start <= 1'b0;
        for (int j = 0; j < LIMBS; j++) begin
            write_word(j, 16'h0f0f);
        end
        write_word(T_LOW_ADDR, 16'h0003);
        cfg_write <= 1'b0;
        wait_for_done();
        // Quiet window starts after the edge that closed the done cycle
        expect_idle <= 1'b1;
        repeat (10) @(posedge clk);
        expect_idle <= 1'b0;
        assert (done_count == dones_before + 1) else begin
            error_count++;
            $display("** Error done_count: expected 0x%h, actual 0x%h",
                     dones_before + 1, done_count);
        end
        start_run({$urandom, $urandom});
        wait_for_done();

        // Back-to-back runs, each started right after done
        load_config(KNOWN_P, 5);
        for (int n = 0; n < 3; n++) begin
            start_run({$urandom, $urandom});
            wait_for_done();
        end
        repeat (5) @(posedge clk);

        assert (expected_q.size() == 0) else begin
            error_count++;
            $display("Runs were started that never reported done");
        end
        prop_fails = modsq_top_inst.modsq_props_inst.fail_count;
        $display("Check errors: %0d, property failures: %0d", error_count, prop_fails);
        if (error_count == 0 && prop_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
